//--- Makefile
# Verilator build and run for the timer testbench

VERILATOR ?= verilator
TOP       ?= tmr_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/tmr_channel.sv
`include "tmr_config.svh"

module tmr_channel (
   input  logic       clk,
   input  logic       io_clk,
   tmr_reg_if.channel bus,
   output logic       irq
);
   import tmr_pkg::*;

   // bit 0 enable, bit 1 interrupt enable
   logic [`TMR_WIDTH-1:0] control;
   logic [`TMR_WIDTH-1:0] ar;
   logic [`TMR_WIDTH-1:0] counter;
   // sticky overflow
   logic                  ovf;

   logic wr;
   logic ctrl_wr;
   logic ar_wr;
   logic cntr_load;
   logic ovf_clr;
   logic enable;
   logic ar_reached;

   // write decode for this channel
   assign wr        = bus.sel && (bus.op == OP_WRITE);
   assign ctrl_wr   = wr && (bus.reg_sel == REG_CTRL);
   assign ar_wr     = wr && (bus.reg_sel == REG_AR);
   assign cntr_load = wr && (bus.reg_sel == REG_CNTR);
   // write 1 to status bit 1 to clear
   assign ovf_clr   = wr && (bus.reg_sel == REG_STAT) && bus.wdata[1];

   assign enable     = control[0];
   assign ar_reached = (counter == ar);

   // control register
   always_ff @(posedge clk, posedge io_clk)
   begin
      if (io_clk)
         control <= '0;
      else if (ctrl_wr)
         control <= bus.wdata;
   end

   // auto-reload register
   always_ff @(posedge clk, posedge io_clk)
   begin
      if (io_clk)
         ar <= '0;
      else if (ar_wr)
         ar <= bus.wdata;
   end

   // counter, a load wins over counting
   always_ff @(posedge clk, posedge io_clk)
   begin
      if (io_clk)
         counter <= '0;
      else if (cntr_load)
         counter <= bus.wdata;
      else if (enable)
      begin
         // wrap to zero once it equals ar
         if (ar_reached)
            counter <= '0;
         else
            counter <= counter + 1'b1;
      end
   end

   // overflow flag, clear has priority
   always_ff @(posedge clk, posedge io_clk)
   begin
      if (io_clk)
         ovf <= 1'b0;
      else if (ovf_clr)
         ovf <= 1'b0;
      else if (enable && !cntr_load && ar_reached)
         ovf <= 1'b1;
   end

   // read mux, combinational from reg_sel
   always_comb
   begin
      case (bus.reg_sel)
         REG_CTRL: bus.rdata = control;
         REG_AR:   bus.rdata = ar;
         REG_CNTR: bus.rdata = counter;
         // overflow in bit 1, enable mirror in bit 0
         REG_STAT: bus.rdata = {{(`TMR_WIDTH-2){1'b0}}, ovf, enable};
         default:  bus.rdata = counter;
      endcase
   end

   // gated by interrupt enable
   assign irq = ovf & control[1];

endmodule

//--- design/tmr_config.svh
`ifndef TMR_CONFIG_SVH
`define TMR_CONFIG_SVH

// data and register width
`define TMR_WIDTH 32

// number of timer channels, 2, 4 or 8
`define TMR_CHANNELS 4

// channel index field in the address
// must be wide enough for TMR_CHANNELS
`define TMR_CH_BITS 2

// register select field in the address
`define TMR_REG_BITS 2

// full bus address, channel index on top
`define TMR_ADDR_BITS (`TMR_CH_BITS + `TMR_REG_BITS)

// extra cycles allowed past the stimulus length
`define TMR_TIMEOUT_MARGIN 50

`endif

//--- design/tmr_host_port.sv
`include "tmr_config.svh"

module tmr_host_port (
   input  logic                     clk,
   input  logic                     io_clk,
   input  logic                     cs,
   input  logic                     wen,
   input  logic [`TMR_ADDR_BITS-1:0] addr,
   input  logic [`TMR_WIDTH-1:0]    din,
   tmr_reg_if.host                  ch [`TMR_CHANNELS],
   output logic [`TMR_CH_BITS-1:0]  rd_ch
);
   import tmr_pkg::*;

   tmr_op_e                 op;
   tmr_reg_e                reg_sel;
   logic [`TMR_CH_BITS-1:0] ch_idx;

   // classify the cycle, plain strobes and no handshake
   always_comb
   begin
      if (!cs)
         op = OP_IDLE;
      else if (wen)
         op = OP_WRITE;
      else
         op = OP_READ;
   end

   // channel index sits above the register select
   assign ch_idx  = addr[`TMR_ADDR_BITS-1:`TMR_REG_BITS];
   assign reg_sel = tmr_reg_e'(addr[`TMR_REG_BITS-1:0]);

   // one-hot select, everything else broadcast
   for (genvar i = 0; i < `TMR_CHANNELS; i++)
   begin : g_ch
      assign ch[i].sel     = (op != OP_IDLE) && (ch_idx == `TMR_CH_BITS'(i));
      assign ch[i].op      = op;
      assign ch[i].reg_sel = reg_sel;
      assign ch[i].wdata   = din;
   end

   // live index so readback captures at the read edge
   assign rd_ch = ch_idx;

endmodule

//--- design/tmr_pkg.sv
`include "tmr_config.svh"

package tmr_pkg;

   // register select within one channel
   typedef enum logic [`TMR_REG_BITS-1:0] {
      REG_CTRL = `TMR_REG_BITS'd0,
      REG_AR   = `TMR_REG_BITS'd1,
      REG_CNTR = `TMR_REG_BITS'd2,
      REG_STAT = `TMR_REG_BITS'd3
   } tmr_reg_e;

   // bus operation, decoded from cs and wen
   typedef enum logic [1:0] {
      OP_IDLE  = 2'd0,
      OP_WRITE = 2'd1,
      OP_READ  = 2'd2
   } tmr_op_e;

endpackage

//--- design/tmr_readback.sv
`include "tmr_config.svh"

module tmr_readback (
   input  logic                    clk,
   input  logic                    io_clk,
   input  logic [`TMR_CH_BITS-1:0] rd_ch,
   input  logic                    rd_stb,
   input  logic [`TMR_WIDTH-1:0]   ch_rdata [`TMR_CHANNELS],
   input  logic [`TMR_CHANNELS-1:0] ch_irq,
   output logic [`TMR_WIDTH-1:0]   dout,
   output logic                    irq,
   output logic [`TMR_CHANNELS-1:0] irq_vec
);

   logic [`TMR_WIDTH-1:0] rd_sel;
   logic                  rd_valid_ch;

   // index field may cover more than the channel count
   assign rd_valid_ch = (32'(rd_ch) < `TMR_CHANNELS);

   // pick the addressed channel
   always_comb
   begin
      if (rd_valid_ch)
         rd_sel = ch_rdata[rd_ch];
      else
         rd_sel = '0;
   end

   // holding register, loads at the read edge
   // and keeps its value until the next read
   always_ff @(posedge clk, posedge io_clk)
   begin
      if (io_clk)
         dout <= '0;
      else if (rd_stb)
         dout <= rd_sel;
   end

   // per-channel lines straight out
   assign irq_vec = ch_irq;

   // summary line
   assign irq = |ch_irq;

endmodule

//--- design/tmr_reg_if.sv
`include "tmr_config.svh"

interface tmr_reg_if;
   import tmr_pkg::*;

   // channel addressed this cycle
   logic                  sel;
   // decoded bus operation
   tmr_op_e               op;
   // register within the channel
   tmr_reg_e              reg_sel;
   logic [`TMR_WIDTH-1:0] wdata;
   // combinational read data from the channel
   logic [`TMR_WIDTH-1:0] rdata;

   // host side drives the access
   modport host (
      output sel,
      output op,
      output reg_sel,
      output wdata,
      input  rdata
   );

   // channel side answers it
   modport channel (
      input  sel,
      input  op,
      input  reg_sel,
      input  wdata,
      output rdata
   );

endinterface

//--- design/tmr_top.sv
`include "tmr_config.svh"

module tmr_top (
   input  logic                      clk,
   input  logic                      io_clk,
   input  logic                      cs,
   input  logic                      wen,
   input  logic [`TMR_ADDR_BITS-1:0] addr,
   input  logic [`TMR_WIDTH-1:0]     din,
   output logic [`TMR_WIDTH-1:0]     dout,
   output logic                      irq,
   output logic [`TMR_CHANNELS-1:0]  irq_vec
);

   // one register interface per channel
   tmr_reg_if ch_if [`TMR_CHANNELS] ();

   logic [`TMR_CH_BITS-1:0]  rd_ch;
   logic                     rd_stb;
   logic [`TMR_WIDTH-1:0]    ch_rdata [`TMR_CHANNELS];
   logic [`TMR_CHANNELS-1:0] ch_irq;

   // read strobe, same cycle as the access
   assign rd_stb = cs & ~wen;

   tmr_host_port u_host_port (
      .clk    (clk),
      .io_clk (io_clk),
      .cs     (cs),
      .wen    (wen),
      .addr   (addr),
      .din    (din),
      .ch     (ch_if),
      .rd_ch  (rd_ch)
   );

   // identical channels
   for (genvar i = 0; i < `TMR_CHANNELS; i++)
   begin : g_chan
      tmr_channel u_channel (
         .clk    (clk),
         .io_clk (io_clk),
         .bus    (ch_if[i]),
         .irq    (ch_irq[i])
      );

      // flatten read data for the readback
      assign ch_rdata[i] = ch_if[i].rdata;
   end

   tmr_readback u_readback (
      .clk      (clk),
      .io_clk   (io_clk),
      .rd_ch    (rd_ch),
      .rd_stb   (rd_stb),
      .ch_rdata (ch_rdata),
      .ch_irq   (ch_irq),
      .dout     (dout),
      .irq      (irq),
      .irq_vec  (irq_vec)
   );

endmodule

//--- sources.f
+incdir+design
design/tmr_pkg.sv
design/tmr_reg_if.sv
design/tmr_host_port.sv
design/tmr_channel.sv
design/tmr_readback.sv
design/tmr_top.sv
verif/tmr_tb.sv

//--- verif/tmr_tb.sv
`include "tmr_config.svh"

module tmr_tb;
   import tmr_pkg::*;

   localparam int CLK_HALF   = 20;
   localparam int DRIVE_DLY  = 2;
   localparam int RST_CYCLES = 3;

   logic                      clk;
   logic                      io_clk;
   logic                      cs;
   logic                      wen;
   logic [`TMR_ADDR_BITS-1:0] addr;
   logic [`TMR_WIDTH-1:0]     din;
   logic [`TMR_WIDTH-1:0]     dout;
   logic                      irq;
   logic [`TMR_CHANNELS-1:0]  irq_vec;

   // stimulus table, one entry per clock cycle
   tmr_op_e                   t_op   [$];
   logic [`TMR_ADDR_BITS-1:0] t_addr [$];
   logic [`TMR_WIDTH-1:0]     t_data [$];
   logic [`TMR_WIDTH-1:0]     t_dout [$];
   logic [`TMR_CHANNELS-1:0]  t_irq  [$];
   string                     t_name [$];

   // reference model of every channel
   logic [`TMR_WIDTH-1:0]    m_ctrl [`TMR_CHANNELS];
   logic [`TMR_WIDTH-1:0]    m_ar   [`TMR_CHANNELS];
   logic [`TMR_WIDTH-1:0]    m_cntr [`TMR_CHANNELS];
   logic [`TMR_CHANNELS-1:0] m_ovf;
   logic [`TMR_WIDTH-1:0]    m_dout;

   int row;
   int cycles;
   int timeout_limit;

   tmr_top dut (
      .clk     (clk),
      .io_clk  (io_clk),
      .cs      (cs),
      .wen     (wen),
      .addr    (addr),
      .din     (din),
      .dout    (dout),
      .irq     (irq),
      .irq_vec (irq_vec)
   );

   always #CLK_HALF clk = ~clk;

   task automatic add_row(input tmr_op_e op, input int ch, input tmr_reg_e rs,
                          input logic [`TMR_WIDTH-1:0] data,
                          input logic [`TMR_WIDTH-1:0] exp_dout,
                          input logic [`TMR_CHANNELS-1:0] exp_irq, input string name);
      t_op.push_back(op);
      // channel index above register select
      t_addr.push_back({ch[`TMR_CH_BITS-1:0], rs});
      t_data.push_back(data);
      t_dout.push_back(exp_dout);
      t_irq.push_back(exp_irq);
      t_name.push_back(name);
   endtask

   task automatic check_value(input string name, input logic [`TMR_WIDTH-1:0] exp,
                              input logic [`TMR_WIDTH-1:0] act);
      if (exp !== act)
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("test failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic model_reset();
      int c;
      for (c = 0; c < `TMR_CHANNELS; c++)
      begin
         m_ctrl[c] = '0;
         m_ar[c]   = '0;
         m_cntr[c] = '0;
      end
      m_ovf  = '0;
      m_dout = '0;
   endtask

   // register value as seen just before the edge
   function automatic logic [`TMR_WIDTH-1:0] model_read(input int c, input tmr_reg_e rs);
      case (rs)
         REG_CTRL: return m_ctrl[c];
         REG_AR:   return m_ar[c];
         REG_CNTR: return m_cntr[c];
         default:  return {{(`TMR_WIDTH-2){1'b0}}, m_ovf[c], m_ctrl[c][0]};
      endcase
   endfunction

   function automatic logic [`TMR_CHANNELS-1:0] model_irq();
      logic [`TMR_CHANNELS-1:0] v;
      int c;
      for (c = 0; c < `TMR_CHANNELS; c++)
         v[c] = m_ovf[c] & m_ctrl[c][1];
      return v;
   endfunction

   // one clock edge of the counting rule
   task automatic model_step(input tmr_op_e op, input logic [`TMR_ADDR_BITS-1:0] a,
                             input logic [`TMR_WIDTH-1:0] data);
      int       ch;
      int       c;
      tmr_reg_e rs;
      logic     hit;
      logic     load;
      logic     clr;
      logic     en;
      logic     reached;
      ch = int'(a[`TMR_ADDR_BITS-1:`TMR_REG_BITS]);
      rs = tmr_reg_e'(a[`TMR_REG_BITS-1:0]);
      if (op == OP_READ)
         m_dout = model_read(ch, rs);
      for (c = 0; c < `TMR_CHANNELS; c++)
      begin
         hit     = (op == OP_WRITE) && (c == ch);
         load    = hit && (rs == REG_CNTR);
         clr     = hit && (rs == REG_STAT) && data[1];
         // old enable and old ar decide this edge
         en      = m_ctrl[c][0];
         reached = (m_cntr[c] == m_ar[c]);
         if (load)
            m_cntr[c] = data;
         else if (en)
            m_cntr[c] = reached ? '0 : m_cntr[c] + `TMR_WIDTH'(1);
         if (clr)
            m_ovf[c] = 1'b0;
         else if (en && !load && reached)
            m_ovf[c] = 1'b1;
         if (hit && (rs == REG_CTRL))
            m_ctrl[c] = data;
         if (hit && (rs == REG_AR))
            m_ar[c] = data;
      end
   endtask

   task automatic drive_row(input int r);
      cs   = (t_op[r] != OP_IDLE);
      wen  = (t_op[r] == OP_WRITE);
      addr = t_addr[r];
      din  = t_data[r];
   endtask

   // table against model, then DUT against table
   task automatic check_row(input int r);
      string nm;
      nm = t_name[r];
      if (t_op[r] == OP_READ)
      begin
         check_value({nm, " model dout"}, t_dout[r], m_dout);
         check_value({nm, " dout"}, t_dout[r], dout);
      end
      check_value({nm, " model irq_vec"}, `TMR_WIDTH'(t_irq[r]), `TMR_WIDTH'(model_irq()));
      check_value({nm, " irq_vec"}, `TMR_WIDTH'(t_irq[r]), `TMR_WIDTH'(irq_vec));
      check_value({nm, " irq"}, `TMR_WIDTH'(|t_irq[r]), `TMR_WIDTH'(irq));
   endtask

   task automatic build_table();
      // everything reads zero out of reset
      add_row(OP_READ,  0, REG_CTRL, 32'h0, 32'h0, 4'b0000, "rst ctrl0");
      add_row(OP_READ,  1, REG_AR,   32'h0, 32'h0, 4'b0000, "rst ar1");
      add_row(OP_READ,  2, REG_CNTR, 32'h0, 32'h0, 4'b0000, "rst cntr2");
      add_row(OP_READ,  3, REG_STAT, 32'h0, 32'h0, 4'b0000, "rst stat3");
      // distinct values, enable and irq enable left off
      add_row(OP_WRITE, 0, REG_CTRL, 32'h1111_0000, 32'h0, 4'b0000, "wr ctrl0");
      add_row(OP_WRITE, 1, REG_CTRL, 32'h2222_0004, 32'h0, 4'b0000, "wr ctrl1");
      add_row(OP_WRITE, 2, REG_CTRL, 32'h3333_0008, 32'h0, 4'b0000, "wr ctrl2");
      add_row(OP_WRITE, 3, REG_CTRL, 32'h4444_000c, 32'h0, 4'b0000, "wr ctrl3");
      add_row(OP_WRITE, 0, REG_AR,   32'h0000_aaa0, 32'h0, 4'b0000, "wr ar0");
      add_row(OP_WRITE, 1, REG_AR,   32'h0000_bbb0, 32'h0, 4'b0000, "wr ar1");
      add_row(OP_WRITE, 2, REG_AR,   32'h0000_ccc0, 32'h0, 4'b0000, "wr ar2");
      add_row(OP_WRITE, 3, REG_AR,   32'h0000_ddd0, 32'h0, 4'b0000, "wr ar3");
      add_row(OP_READ,  0, REG_CTRL, 32'h0, 32'h1111_0000, 4'b0000, "rd ctrl0");
      add_row(OP_READ,  1, REG_CTRL, 32'h0, 32'h2222_0004, 4'b0000, "rd ctrl1");
      add_row(OP_READ,  2, REG_CTRL, 32'h0, 32'h3333_0008, 4'b0000, "rd ctrl2");
      add_row(OP_READ,  3, REG_CTRL, 32'h0, 32'h4444_000c, 4'b0000, "rd ctrl3");
      add_row(OP_READ,  0, REG_AR,   32'h0, 32'h0000_aaa0, 4'b0000, "rd ar0");
      add_row(OP_READ,  1, REG_AR,   32'h0, 32'h0000_bbb0, 4'b0000, "rd ar1");
      add_row(OP_READ,  2, REG_AR,   32'h0, 32'h0000_ccc0, 4'b0000, "rd ar2");
      add_row(OP_READ,  3, REG_AR,   32'h0, 32'h0000_ddd0, 4'b0000, "rd ar3");
      // channel 1 counts from 5 up toward 100
      add_row(OP_WRITE, 1, REG_CNTR, 32'd5,   32'h0, 4'b0000, "load cntr1");
      add_row(OP_WRITE, 1, REG_AR,   32'd100, 32'h0, 4'b0000, "ar1 100");
      add_row(OP_WRITE, 1, REG_CTRL, 32'd1,   32'h0, 4'b0000, "enable ch1");
      add_row(OP_IDLE,  0, REG_CTRL, 32'h0,   32'h0, 4'b0000, "count idle 1");
      add_row(OP_IDLE,  0, REG_CTRL, 32'h0,   32'h0, 4'b0000, "count idle 2");
      add_row(OP_IDLE,  0, REG_CTRL, 32'h0,   32'h0, 4'b0000, "count idle 3");
      add_row(OP_READ,  1, REG_CNTR, 32'h0,   32'd8, 4'b0000, "count rd");
      // disable edge still counts once, then holds
      add_row(OP_WRITE, 1, REG_CTRL, 32'd0,   32'h0,  4'b0000, "disable ch1");
      add_row(OP_IDLE,  0, REG_CTRL, 32'h0,   32'h0,  4'b0000, "hold idle 1");
      add_row(OP_IDLE,  0, REG_CTRL, 32'h0,   32'h0,  4'b0000, "hold idle 2");
      add_row(OP_READ,  1, REG_CNTR, 32'h0,   32'd10, 4'b0000, "hold rd");
      // load beats the increment
      add_row(OP_WRITE, 1, REG_CTRL, 32'd1,   32'h0,  4'b0000, "reenable ch1");
      add_row(OP_WRITE, 1, REG_CNTR, 32'd50,  32'h0,  4'b0000, "load while counting");
      add_row(OP_READ,  1, REG_CNTR, 32'h0,   32'd50, 4'b0000, "override rd");
      // channel 2 wraps at 3
      add_row(OP_WRITE, 2, REG_AR,   32'd3,   32'h0,  4'b0000, "ar2 3");
      add_row(OP_WRITE, 2, REG_CTRL, 32'd1,   32'h0,  4'b0000, "enable ch2");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd0,  4'b0000, "wrap 0");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd1,  4'b0000, "wrap 1");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd2,  4'b0000, "wrap 2");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd3,  4'b0000, "wrap 3");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd0,  4'b0000, "wrap to 0");
      add_row(OP_READ,  2, REG_STAT, 32'h0,   32'd3,  4'b0000, "ovf set");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd2,  4'b0000, "wrap again 2");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd3,  4'b0000, "wrap again 3");
      add_row(OP_READ,  2, REG_STAT, 32'h0,   32'd3,  4'b0000, "ovf sticky");
      // irq only once irq enable is on
      add_row(OP_WRITE, 2, REG_CTRL, 32'd3,   32'h0,  4'b0100, "irq enable ch2");
      add_row(OP_READ,  2, REG_STAT, 32'h0,   32'd3,  4'b0100, "irq stat");
      add_row(OP_WRITE, 2, REG_STAT, 32'd2,   32'h0,  4'b0000, "clear ovf");
      add_row(OP_WRITE, 2, REG_CTRL, 32'd2,   32'h0,  4'b0000, "disable ch2");
      add_row(OP_READ,  2, REG_STAT, 32'h0,   32'd0,  4'b0000, "stat cleared");
      add_row(OP_IDLE,  0, REG_CTRL, 32'h0,   32'h0,  4'b0000, "ch2 idle");
      add_row(OP_READ,  2, REG_CNTR, 32'h0,   32'd1,  4'b0000, "ch2 held");
      add_row(OP_READ,  0, REG_CTRL, 32'h0, 32'h1111_0000, 4'b0000, "ctrl0 intact");
   endtask

   initial
   begin
      clk    = 1'b0;
      io_clk = 1'b1;
      cs     = 1'b0;
      wen    = 1'b0;
      addr   = '0;
      din    = '0;
      model_reset();
      build_table();
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      io_clk = 1'b0;
      for (row = 0; row < t_op.size(); row++)
      begin
         drive_row(row);
         model_step(t_op[row], t_addr[row], t_data[row]);
         @(posedge clk);
         #DRIVE_DLY;
         // results of this row are settled one cycle after issue
         check_row(row);
      end
      cs  = 1'b0;
      wen = 1'b0;
      $display("test passed");
      $finish;
   end

   // run limit from table length
   initial
   begin
      cycles = 0;
      #1;
      timeout_limit = RST_CYCLES + t_op.size() + `TMR_TIMEOUT_MARGIN;
      while (cycles < timeout_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, the run went past %0d clock cycles", timeout_limit);
      $display("test failed");
      $fatal(1, "simulation timed out");
   end

endmodule
